// File: rtl/fetch_macros.svh
// reset pc and SRAM widths of the fetch front end, included wherever these values are needed
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first fetch address after reset
`define FETCH_PC_RESETVAL 32'h8000_0000

// architectural pc width
`define FETCH_PC_WD 32

// instruction SRAM, 64-bit words addressed by pc[31:3]
`define FETCH_SRAM_ADDR_WD 29
`define FETCH_SRAM_DATA_WD 64

`endif

// File: rtl/cpu_types_pkg.sv
// architectural width types shared by every stage and the SRAM ports, referenced by scoped name
`include "fetch_macros.svh"

package cpu_types_pkg;

  // program counter
  typedef logic [`FETCH_PC_WD-1:0] pc_t;

  // one rv32 instruction
  typedef logic [31:0] inst_t;

  typedef logic [`FETCH_SRAM_ADDR_WD-1:0] sram_addr_t; // word address, pc[31:3]
  typedef logic [`FETCH_SRAM_DATA_WD-1:0] sram_data_t; // two instructions per word

endpackage

// File: rtl/pipe_bus_pkg.sv
// packed buses handed between pipeline stages and back to the pc generator
package pipe_bus_pkg;

  // fetch to decode
  typedef struct packed {
    cpu_types_pkg::pc_t   pc;
    cpu_types_pkg::inst_t inst;
  } fs_to_ds_bus_t;

  // redirect from decode, one cycle pulse per taken jal
  typedef struct packed {
    logic               br_taken;
    cpu_types_pkg::pc_t br_target;
  } br_bus_t;

  // decode to execute
  typedef struct packed {
    cpu_types_pkg::pc_t   pc;
    cpu_types_pkg::inst_t inst;
    logic                 is_jal;
    cpu_types_pkg::pc_t   link; // pc + 4
  } ds_to_es_bus_t;

endpackage

// File: rtl/pc_gen.sv
// pre-fetch stage, keeps the fetch pc and issues instruction SRAM reads for the fetch stage
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pc_gen (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_fs_allowin,
  input  pipe_bus_pkg::br_bus_t     i_br,
  output cpu_types_pkg::pc_t        o_fs_pc,
  output logic                      o_inst_sram_ren,
  output cpu_types_pkg::sram_addr_t o_inst_sram_addr,
  output logic                      o_fetch_issue
);

  cpu_types_pkg::pc_t pc_q;     // pc of the latest issued fetch
  cpu_types_pkg::pc_t next_pc;
  logic               fetch_en; // low through reset
  logic               issue;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fetch_en <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
    end
  end

  // redirect wins over sequential flow
  assign next_pc = i_br.br_taken ? i_br.br_target : pc_q + 32'd4;

  // fetch must have room, or its content is wrong-path anyway
  assign issue = fetch_en && (i_fs_allowin || i_br.br_taken);

  // one word below reset value so the first issue lands on it
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q <= `FETCH_PC_RESETVAL - 32'd4;
    end else if (issue) begin
      pc_q <= next_pc;
    end
  end

  assign o_fs_pc          = pc_q;
  assign o_inst_sram_ren  = issue;
  assign o_inst_sram_addr = next_pc[`FETCH_PC_WD-1:3]; // 64-bit word address
  assign o_fetch_issue    = issue;

endmodule

// File: rtl/if_stage.sv
// fetch stage, picks the instruction out of the SRAM word and hands it to decode
`timescale 1ns/1ps

module if_stage (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_fetch_issue,
  input  pipe_bus_pkg::br_bus_t       i_br,
  input  cpu_types_pkg::pc_t          i_fs_pc,
  input  cpu_types_pkg::sram_data_t   i_inst_sram_rdata,
  input  logic                        i_ds_allowin,
  output logic                        o_fs_allowin,
  output logic                        o_fs_to_ds_valid,
  output pipe_bus_pkg::fs_to_ds_bus_t o_fs_to_ds_bus
);

  logic                 fs_valid;
  cpu_types_pkg::inst_t fs_inst;

  // ready_go is always high, every fetch completes in one cycle
  assign o_fs_allowin     = !fs_valid || i_ds_allowin;
  assign o_fs_to_ds_valid = fs_valid;

  // on a taken branch the wrong-path fetch is overwritten by the target fetch
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fs_valid <= 1'b0;
    end else if (o_fs_allowin || i_br.br_taken) begin
      fs_valid <= i_fetch_issue;
    end
  end

  // rdata is held by the SRAM until the next read, so no local copy
  assign fs_inst = i_fs_pc[2] ? i_inst_sram_rdata[63:32]  // upper half
                              : i_inst_sram_rdata[31:0];

  assign o_fs_to_ds_bus.pc   = i_fs_pc;
  assign o_fs_to_ds_bus.inst = fs_inst;

  // a full fetch blocked by decode must not start another read
  ap_no_issue_when_blocked : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    fs_valid && !i_ds_allowin |-> !i_fetch_issue
  ) else $error("fetch issued while fetch full and decode stalled");

endmodule

// File: rtl/id_stage.sv
// decode stage that resolves jal and sends the redirect back while passing instructions to execute
`timescale 1ns/1ps

module id_stage (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_fs_to_ds_valid,
  input  pipe_bus_pkg::fs_to_ds_bus_t i_fs_to_ds_bus,
  input  logic                        i_es_allowin,
  output logic                        o_ds_allowin,
  output pipe_bus_pkg::br_bus_t       o_br,
  output logic                        o_ds_to_es_valid,
  output pipe_bus_pkg::ds_to_es_bus_t o_ds_to_es_bus
);

  localparam logic [6:0] OPC_JAL = 7'b1101111;

  logic                        ds_valid;
  pipe_bus_pkg::fs_to_ds_bus_t ds_bus_q; // held instruction payload
  logic                        is_jal;
  logic                        br_taken;
  cpu_types_pkg::pc_t          j_imm;
  cpu_types_pkg::pc_t          link_pc;

  assign o_ds_allowin = !ds_valid || i_es_allowin;

  // jal resolves when it leaves decode
  assign is_jal   = ds_bus_q.inst[6:0] == OPC_JAL;
  assign br_taken = ds_valid && is_jal && i_es_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !br_taken; // incoming inst is wrong-path
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ds_allowin && i_fs_to_ds_valid) begin
      ds_bus_q <= i_fs_to_ds_bus;
    end
  end

  // j-type immediate with bit 0 always zero
  assign j_imm = {{11{ds_bus_q.inst[31]}},
                  ds_bus_q.inst[31],
                  ds_bus_q.inst[19:12],
                  ds_bus_q.inst[20],
                  ds_bus_q.inst[30:21],
                  1'b0};

  assign link_pc = ds_bus_q.pc + 32'd4;

  assign o_br.br_taken  = br_taken;
  assign o_br.br_target = ds_bus_q.pc + j_imm;

  assign o_ds_to_es_valid      = ds_valid;
  assign o_ds_to_es_bus.pc     = ds_bus_q.pc;
  assign o_ds_to_es_bus.inst   = ds_bus_q.inst;
  assign o_ds_to_es_bus.is_jal = is_jal;
  assign o_ds_to_es_bus.link   = link_pc;

  // fetch keeps offering the same instruction until decode takes it
  ap_fetch_hold_on_stall : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_fs_to_ds_valid && !o_ds_allowin |=> i_fs_to_ds_valid && $stable(i_fs_to_ds_bus)
  ) else $error("fetch output changed while decode stalled");

endmodule

// File: rtl/fetch_top.sv
// top of the instruction front end, wires the pc generator, fetch and decode to SRAM and execute
`timescale 1ns/1ps

module fetch_top (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  // inst sram
  output logic                        o_inst_sram_ren,
  output cpu_types_pkg::sram_addr_t   o_inst_sram_addr,
  input  cpu_types_pkg::sram_data_t   i_inst_sram_rdata,
  // to execute
  input  logic                        i_es_allowin,
  output logic                        o_ds_to_es_valid,
  output pipe_bus_pkg::ds_to_es_bus_t o_ds_to_es_bus
);

  logic                        fs_allowin;
  logic                        ds_allowin;
  logic                        fetch_issue;
  cpu_types_pkg::pc_t          fs_pc;
  logic                        fs_to_ds_valid;
  pipe_bus_pkg::fs_to_ds_bus_t fs_to_ds_bus;
  pipe_bus_pkg::br_bus_t       br;          // redirect from decode

  pc_gen u_pc_gen (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_allowin     (fs_allowin),
    .i_br             (br),
    .o_fs_pc          (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr),
    .o_fetch_issue    (fetch_issue)
  );

  if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_fetch_issue     (fetch_issue),
    .i_br              (br),
    .i_fs_pc           (fs_pc),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .i_ds_allowin      (ds_allowin),
    .o_fs_allowin      (fs_allowin),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_to_ds_bus    (fs_to_ds_bus)
  );

  id_stage u_id_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds_bus   (fs_to_ds_bus),
    .i_es_allowin     (i_es_allowin),
    .o_ds_allowin     (ds_allowin),
    .o_br             (br),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es_bus   (o_ds_to_es_bus)
  );

endmodule

// File: tb/tb_fetch_top.sv
// self-checking testbench for fetch_top, models the instruction SRAM and checks the decode output stream
`timescale 1ns/1ps
`include "fetch_macros.svh"

module tb_fetch_top;

  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DLY   = 2;
  localparam int MEM_WORDS   = 64;           // 512 byte window at the reset pc
  localparam int NUM_PROG    = 5;
  localparam int NUM_EXP     = 21;
  localparam int CYCLE_LIMIT = 4 * NUM_EXP + 50;

  localparam logic [31:0] RESET_PC  = `FETCH_PC_RESETVAL;
  localparam logic [28:0] BASE_WORD = RESET_PC[31:3];
  localparam logic [6:0]  OPC_JAL   = 7'b1101111;
  localparam logic [6:0]  OPC_OPIMM = 7'b0010011;

  // program table, jal at offset -> target offset, everything else is fill
  localparam logic [31:0] PROG_OFF [NUM_PROG] = '{32'h14, 32'h48, 32'h28, 32'h2c, 32'h58};
  localparam logic [31:0] PROG_TGT [NUM_PROG] = '{32'h40, 32'h20, 32'h58, 32'h12c, 32'h70};

  // expected output stream, pc offset and jal flag
  localparam logic [31:0] EXP_OFF [NUM_EXP] = '{
    32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14,  // upper-half jal forward
    32'h40, 32'h44, 32'h48,                          // jal backward
    32'h20, 32'h24, 32'h28,                          // 0x2c is a wrong-path jal
    32'h58,                                          // second jal in a row
    32'h70, 32'h74, 32'h78, 32'h7c, 32'h80, 32'h84, 32'h88, 32'h8c
  };
  localparam bit EXP_JAL [NUM_EXP] = '{
    1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b0, 1'b1,
    1'b0, 1'b0, 1'b1,
    1'b1,
    1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0
  };

  logic                        i_clk;
  logic                        i_rst_n;
  logic                        i_es_allowin;
  cpu_types_pkg::sram_data_t   i_inst_sram_rdata = '0;
  logic                        o_inst_sram_ren;
  cpu_types_pkg::sram_addr_t   o_inst_sram_addr;
  logic                        o_ds_to_es_valid;
  pipe_bus_pkg::ds_to_es_bus_t o_ds_to_es_bus;

  cpu_types_pkg::sram_data_t mem [MEM_WORDS];
  logic [31:0]               lfsr;
  int                        err_count;
  int                        check_count;
  bit                        hung;

  fetch_top i_dut (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .i_es_allowin      (i_es_allowin),
    .o_ds_to_es_valid  (o_ds_to_es_valid),
    .o_ds_to_es_bus    (o_ds_to_es_bus)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // plain addi, upper bits folded from the whole pc
  function automatic logic [31:0] fill_inst(input logic [31:0] pc);
    return {pc[31:7] ^ pc[26:2], OPC_OPIMM};
  endfunction

  // j-type, rd = x1
  function automatic logic [31:0] encode_jal(input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
  endfunction

  function automatic logic [31:0] inst_at(input logic [31:0] pc);
    for (int i = 0; i < NUM_PROG; i++) begin
      if (pc == RESET_PC + PROG_OFF[i]) begin
        return encode_jal(PROG_TGT[i] - PROG_OFF[i]);
      end
    end
    return fill_inst(pc);
  endfunction

  function automatic cpu_types_pkg::sram_data_t read_word(input logic [28:0] addr);
    logic [28:0] rel;
    rel = addr - BASE_WORD;
    if (rel[28:6] == '0) begin
      return mem[rel[5:0]];
    end
    return {fill_inst({addr, 3'b100}), fill_inst({addr, 3'b000})}; // outside the window
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_random_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one-cycle read latency, word held until the next read
  always @(posedge i_clk) begin
    if (o_inst_sram_ren) begin
      i_inst_sram_rdata <= read_word(o_inst_sram_addr);
    end
  end

  task automatic apply_reset();
    @(posedge i_clk);
    #DRIVE_DLY;
    i_rst_n      = 1'b0;
    i_es_allowin = 1'b1;
    repeat (2) begin
      @(negedge i_clk);
      check_value("ren in reset", {31'b0, o_inst_sram_ren}, 32'd0);
      check_value("valid in reset", {31'b0, o_ds_to_es_valid}, 32'd0);
      @(posedge i_clk);
      #DRIVE_DLY;
    end
    i_rst_n = 1'b1;
  endtask

  task automatic run_stream(input int test_id, input bit throttle, output bit timed_out);
    int          idx;
    int          cycles;
    int          last_cycle;
    int          first_ren;
    int          errs_before;
    logic        ready;
    logic [31:0] pc;
    idx         = 0;
    cycles      = 0;
    last_cycle  = 0;
    first_ren   = -1;
    errs_before = err_count;
    timed_out   = 1'b0;
    apply_reset();
    while (idx < NUM_EXP && !timed_out) begin
      @(posedge i_clk);
      #DRIVE_DLY;
      ready = 1'b1;
      if (throttle) begin
        take_random_bit(ready);
      end
      i_es_allowin = ready;
      @(negedge i_clk);  // inputs and outputs settled here
      cycles++;
      if (o_inst_sram_ren && first_ren < 0) begin
        first_ren = cycles;
      end
      if (o_ds_to_es_valid && i_es_allowin) begin
        pc = RESET_PC + EXP_OFF[idx];
        check_value("pc", o_ds_to_es_bus.pc, pc);
        check_value("inst", o_ds_to_es_bus.inst, inst_at(pc));
        check_value("is_jal", {31'b0, o_ds_to_es_bus.is_jal}, {31'b0, EXP_JAL[idx]});
        check_value("link", o_ds_to_es_bus.link, pc + 32'd4);
        if (!throttle && idx == 0) begin
          check_value("first output delay", cycles - first_ren, 32'd2);
        end else if (!throttle) begin
          // one bubble after a taken jal, none otherwise
          check_value("output spacing", cycles - last_cycle, EXP_JAL[idx - 1] ? 32'd2 : 32'd1);
        end
        last_cycle = cycles;
        idx++;
      end
      if (cycles >= CYCLE_LIMIT) begin
        $display("test %0d timed out after %0d cycles with %0d of %0d instructions received",
                 test_id, cycles, idx, NUM_EXP);
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      $display("test %0d (%s): %0d instructions in %0d cycles, %0d errors", test_id,
               throttle ? "random back-pressure" : "full rate", idx, cycles,
               err_count - errs_before);
    end
  endtask

  initial begin
    logic [31:0] pc;
    i_rst_n      = 1'b0;
    i_es_allowin = 1'b0;
    lfsr         = 32'h4971_c7cb;
    err_count    = 0;
    check_count  = 0;
    hung         = 1'b0;
    for (int w = 0; w < MEM_WORDS; w++) begin
      pc     = RESET_PC + 32'(w) * 32'd8;
      mem[w] = {inst_at(pc + 32'd4), inst_at(pc)};  // pc bit 2 picks the upper half
    end
    run_stream(1, 1'b0, hung);
    if (!hung) begin
      run_stream(2, 1'b1, hung);
    end
    $display("%0d checks, %0d errors", check_count, err_count);
    if (hung || err_count != 0) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/pipe_bus_pkg.sv
rtl/pc_gen.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/fetch_top.sv
tb/tb_fetch_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_fetch_top
FILELIST  := filelist.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SIM_LOG   := sim.log
PASS_MSG  := Finished with no errors
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv) $(FILELIST)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -qx "$(PASS_MSG)" $(SIM_LOG) && echo "simulation passed" || \
		{ echo "simulation failed"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
